//--- Bender.yml
package:
  name: predecode

sources:
  - include_dirs:
      - src
    files:
      - src/predecode_isa_pkg.sv
      - src/predecode_pipe_pkg.sv
      - src/predecode_branch_decode.sv
      - src/predecode_ras.sv
      - src/predecode_predictor.sv
      - src/predecode_stage_reg.sv
      - src/predecode_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/predecode_properties.sv
      - testbench/predecode_tb.sv

//--- all.f
+incdir+src
src/predecode_isa_pkg.sv
src/predecode_pipe_pkg.sv
src/predecode_branch_decode.sv
src/predecode_ras.sv
src/predecode_predictor.sv
src/predecode_stage_reg.sv
src/predecode_top.sv
testbench/predecode_properties.sv
testbench/predecode_tb.sv

//--- src/predecode_branch_decode.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module predecode_branch_decode
(
        input  predecode_pipe_pkg::fetch_bundle_t  i_instr,
        input  logic                               i_cpu_mode_t,
        output predecode_isa_pkg::branch_class_t   o_class,
        output logic                               o_link,
        output logic                               o_always,
        output logic [`PREDECODE_XLEN-1:0]         o_target,
        output logic [`PREDECODE_XLEN-1:0]         o_fallthrough
);

predecode_isa_pkg::instr_fields_t  fields;
logic                              is_branch;
logic                              is_return;
logic [`PREDECODE_XLEN-1:0]        offset_sext;

always_comb fields = predecode_isa_pkg::instr_fields_t'(i_instr.instr);

////////////////////////////////////////
// Pattern match.
////////////////////////////////////////

// B or BL.
always_comb is_branch = i_instr.valid && (fields.op == predecode_isa_pkg::OP_BRANCH);

// BX LR, MOV PC,LR or LDM with PC in the list.
always_comb
begin
        is_return = 1'b0;

        if ( i_instr.instr[31:0] ==? predecode_isa_pkg::BX_LR )
                is_return = 1'b1;

        if ( i_instr.instr ==? predecode_isa_pkg::MOV_PC_LR )
                is_return = 1'b1;

        // L bit 20, PC is register 15.
        if ( fields.op == predecode_isa_pkg::OP_LDM && fields.offset[20] && fields.offset[15] )
                is_return = 1'b1;

        is_return = is_return && i_instr.valid;
end

always_comb
begin
        if ( is_branch )
                o_class = predecode_isa_pkg::CLASS_CALL;
        else if ( is_return )
                o_class = predecode_isa_pkg::CLASS_RETURN;
        else if ( i_instr.valid )
                o_class = predecode_isa_pkg::CLASS_OTHER;
        else
                o_class = predecode_isa_pkg::CLASS_NONE;
end

always_comb o_link   = fields.link;
always_comb o_always = (fields.cond == predecode_isa_pkg::AL);

////////////////////////////////////////
// Addresses.
////////////////////////////////////////

always_comb offset_sext = {{(`PREDECODE_XLEN-24){fields.offset[23]}}, fields.offset};

// Halfword or word scaled offset from PC+8.
always_comb
begin
        if ( fields.ext[2] )
                o_target = i_instr.pc_plus_8 + (offset_sext << 1);
        else
                o_target = i_instr.pc_plus_8 + (offset_sext << 2);
end

always_comb
begin
        if ( i_cpu_mode_t )
                o_fallthrough = i_instr.pc + `PREDECODE_XLEN'(`PREDECODE_THUMB_STEP);
        else
                o_fallthrough = i_instr.pc + `PREDECODE_XLEN'(`PREDECODE_ARM_STEP);
end

endmodule

//--- src/predecode_isa_pkg.sv
`include "predecode_settings.svh"

package predecode_isa_pkg;

        ////////////////////////////////////////
        // Branch state and condition codes.
        ////////////////////////////////////////

        // Two-bit saturating branch state.
        typedef enum logic [1:0] {
                SNT = 2'b00,
                WNT = 2'b01,
                WT  = 2'b10,
                ST  = 2'b11
        } branch_state_t;

        typedef logic [3:0] cond_t;

        // Always.
        localparam cond_t AL = 4'b1110;

        // Result of pre-decode classification.
        typedef enum logic [1:0] {
                CLASS_NONE,
                CLASS_CALL,
                CLASS_RETURN,
                CLASS_OTHER
        } branch_class_t;

        ////////////////////////////////////////
        // Instruction fields.
        ////////////////////////////////////////

        // Branch-format view of the 35-bit word.
        typedef struct packed {
                logic [2:0]  ext;
                cond_t       cond;
                logic [2:0]  op;
                logic        link;
                logic [23:0] offset;
        } instr_fields_t;

        localparam logic [2:0] OP_BRANCH = 3'b101;
        localparam logic [2:0] OP_LDM    = 3'b100;

        // BX LR, any condition.
        localparam logic [31:0] BX_LR = 32'b????_0001_0010_1111_1111_1111_0001_1110;

        // MOV PC, LR, any condition.
        localparam logic [34:0] MOV_PC_LR =
                35'b000_????_0001_1010_0000_1111_0000_0000_1110;

endpackage

//--- src/predecode_pipe_pkg.sv
`include "predecode_settings.svh"

package predecode_pipe_pkg;

        ////////////////////////////////////////
        // Fetch side.
        ////////////////////////////////////////

        // Instruction and side information from fetch.
        typedef struct packed {
                predecode_isa_pkg::branch_state_t taken;
                logic                             force32;
                logic                             und;
                logic                             irq;
                logic                             fiq;
                logic                             abt;
                logic [`PREDECODE_XLEN-1:0]       pc;
                logic [`PREDECODE_XLEN-1:0]       pc_plus_8;
                logic [`PREDECODE_INSTR_W-1:0]    instr;
                logic                             valid;
        } fetch_bundle_t;

        // Clears and stalls, highest priority first.
        typedef struct packed {
                logic clear_wb;
                logic data_stall;
                logic clear_alu;
                logic stall_shifter;
                logic stall_issue;
        } pipe_ctrl_t;

        ////////////////////////////////////////
        // Decode side.
        ////////////////////////////////////////

        // PC correction towards fetch.
        typedef struct packed {
                logic                       valid;
                logic [`PREDECODE_XLEN-1:0] pc;
        } redirect_t;

        // Registered bundle handed to decode.
        typedef struct packed {
                logic [`PREDECODE_INSTR_W-1:0]    instr;
                logic                             valid;
                predecode_isa_pkg::branch_state_t taken;
                logic                             force32align;
                logic                             irq;
                logic                             fiq;
                logic                             abt;
                logic                             und;
                logic [`PREDECODE_XLEN-1:0]       pc;
                logic [`PREDECODE_XLEN-1:0]       pc_plus_8;
                logic [`PREDECODE_XLEN-1:0]       ppc;
        } decode_bundle_t;

endpackage

//--- src/predecode_predictor.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module predecode_predictor
(
        input  predecode_pipe_pkg::fetch_bundle_t   i_fetch,
        input  predecode_isa_pkg::branch_class_t    i_class,
        input  logic                                i_link,
        input  logic                                i_always,
        input  logic [`PREDECODE_XLEN-1:0]          i_target,
        input  logic [`PREDECODE_XLEN-1:0]          i_fallthrough,
        input  logic                                i_pred_valid,
        input  logic [`PREDECODE_XLEN-1:0]          i_pred_pc,
        input  logic [`PREDECODE_XLEN-1:0]          i_ras_top,
        input  logic [`PREDECODE_XLEN-1:0]          i_ppc_ff,
        output predecode_pipe_pkg::decode_bundle_t  o_next,
        output predecode_pipe_pkg::redirect_t       o_redirect_next,
        output logic                                o_push,
        output logic                                o_pop,
        output logic [`PREDECODE_XLEN-1:0]          o_push_addr,
        output logic                                o_clear_btb
);

predecode_isa_pkg::branch_state_t   taken_nxt;
logic [`PREDECODE_XLEN-1:0]         ppc_nxt;
logic                               predict_taken;
logic                               is_call;

always_comb is_call = (i_class == predecode_isa_pkg::CLASS_CALL);

// Weakly or strongly taken, or unconditional.
always_comb predict_taken = (i_fetch.taken == predecode_isa_pkg::WT) ||
                            (i_fetch.taken == predecode_isa_pkg::ST) || i_always;

// Return address of a linked call.
always_comb o_push_addr = i_fallthrough;

////////////////////////////////////////
// Static prediction.
////////////////////////////////////////

always_comb
begin
        taken_nxt       = i_fetch.taken;
        ppc_nxt         = i_ppc_ff;
        o_redirect_next = '0;
        o_push          = 1'b0;
        o_pop           = 1'b0;
        o_clear_btb     = 1'b0;

        case ( i_class )
        predecode_isa_pkg::CLASS_CALL, predecode_isa_pkg::CLASS_RETURN:
        begin
                if ( predict_taken )
                begin
                        ppc_nxt               = is_call ? i_target : i_ras_top;
                        o_redirect_next.pc    = ppc_nxt;
                        // Fetch already went there.
                        o_redirect_next.valid = !(i_pred_valid && i_pred_pc == ppc_nxt);

                        if ( i_always )
                                taken_nxt = predecode_isa_pkg::ST;

                        o_push = is_call && i_link;
                        o_pop  = !is_call;
                end
                else
                begin
                        ppc_nxt = i_fallthrough;
                end
        end

        predecode_isa_pkg::CLASS_OTHER:
        begin
                taken_nxt = predecode_isa_pkg::SNT;

                // Stale BTB hit on a non-branch.
                if ( i_pred_valid )
                begin
                        ppc_nxt               = i_fallthrough;
                        o_redirect_next.valid = 1'b1;
                        o_redirect_next.pc    = i_fallthrough;
                        o_clear_btb           = 1'b1;
                end
        end

        default:
        begin
                taken_nxt = predecode_isa_pkg::SNT;
        end
        endcase
end

////////////////////////////////////////
// Bundle towards decode.
////////////////////////////////////////

always_comb
begin
        o_next.instr        = i_fetch.instr;
        o_next.valid        = i_fetch.valid;
        o_next.taken        = taken_nxt;
        o_next.force32align = i_fetch.force32;
        o_next.irq          = i_fetch.irq;
        o_next.fiq          = i_fetch.fiq;
        o_next.abt          = i_fetch.abt;
        o_next.und          = i_fetch.und && i_fetch.valid;
        o_next.pc           = i_fetch.pc;
        o_next.pc_plus_8    = i_fetch.pc_plus_8;
        o_next.ppc          = ppc_nxt;
end

endmodule

//--- src/predecode_ras.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module predecode_ras
(
        input  logic                                       i_clk,
        input  logic                                       i_reset,
        input  logic                                       i_advance,
        input  logic                                       i_push,
        input  logic                                       i_pop,
        input  logic [`PREDECODE_XLEN-1:0]                 i_push_addr,
        output logic [`PREDECODE_XLEN-1:0]                 o_top_addr,
        output logic [$clog2(`PREDECODE_RAS_DEPTH)-1:0]    o_ptr
);

logic [`PREDECODE_RAS_DEPTH-1:0][`PREDECODE_XLEN-1:0]  ras_q;
logic [$clog2(`PREDECODE_RAS_DEPTH)-1:0]               ptr_q;
logic [$clog2(`PREDECODE_RAS_DEPTH)-1:0]               top_idx;

// Pointer addresses the next free slot and wraps.
always_comb top_idx    = ptr_q - 1'b1;
always_comb o_top_addr = ras_q[top_idx];
always_comb o_ptr      = ptr_q;

always_ff @ (posedge i_clk)
begin
        if ( i_reset )
        begin
                ras_q <= '0;
                ptr_q <= '0;
        end
        else if ( i_advance )
        begin
                if ( i_push )
                begin
                        ras_q[ptr_q] <= i_push_addr;
                        ptr_q        <= ptr_q + 1'b1;
                end
                else if ( i_pop )
                begin
                        ptr_q <= top_idx;
                end
        end
end

endmodule

//--- src/predecode_settings.svh
`ifndef PREDECODE_SETTINGS_SVH
`define PREDECODE_SETTINGS_SVH

////////////////////////////////////////
// Datapath widths.
////////////////////////////////////////

// Data and address width.
`define PREDECODE_XLEN 32

// Instruction word. Bit 34 selects halfword-scaled branch offsets.
`define PREDECODE_INSTR_W 35

////////////////////////////////////////
// Prediction.
////////////////////////////////////////

// Return address stack entries.
`define PREDECODE_RAS_DEPTH 8

// Sequential PC increments.
`define PREDECODE_ARM_STEP 4
`define PREDECODE_THUMB_STEP 2

`endif

//--- src/predecode_stage_reg.sv
`timescale 1ns/1ps

module predecode_stage_reg
(
        input  logic                                i_clk,
        input  logic                                i_reset,
        input  predecode_pipe_pkg::pipe_ctrl_t      i_ctrl,
        input  predecode_pipe_pkg::decode_bundle_t  i_next,
        input  predecode_pipe_pkg::redirect_t       i_redirect_next,
        output predecode_pipe_pkg::decode_bundle_t  o_decode,
        output predecode_pipe_pkg::redirect_t       o_redirect,
        output logic                                o_advance
);

// Drops valid, branch state and events. Payload stays.
function automatic predecode_pipe_pkg::decode_bundle_t flags_cleared
(
        input predecode_pipe_pkg::decode_bundle_t b
);
        predecode_pipe_pkg::decode_bundle_t r;

        r       = b;
        r.valid = 1'b0;
        r.taken = predecode_isa_pkg::SNT;
        r.irq   = 1'b0;
        r.fiq   = 1'b0;
        r.abt   = 1'b0;
        r.und   = 1'b0;
        return r;
endfunction

// Loads only when nothing above it in the chain is active.
always_comb o_advance = !( i_ctrl.clear_wb      ||
                           i_ctrl.data_stall    ||
                           i_ctrl.clear_alu     ||
                           i_ctrl.stall_shifter ||
                           i_ctrl.stall_issue   ||
                           o_redirect.valid );

////////////////////////////////////////
// Priority chain.
////////////////////////////////////////

always_ff @ (posedge i_clk)
begin
        if ( i_reset )
        begin
                o_decode   <= '0;
                o_redirect <= '0;
        end
        else if ( i_ctrl.clear_wb )
        begin
                o_decode         <= flags_cleared(o_decode);
                o_redirect.valid <= 1'b0;
        end
        else if ( i_ctrl.data_stall )
        begin
                // Hold.
        end
        else if ( i_ctrl.clear_alu )
        begin
                o_decode         <= flags_cleared(o_decode);
                o_redirect.valid <= 1'b0;
        end
        else if ( i_ctrl.stall_shifter || i_ctrl.stall_issue )
        begin
                // Hold.
        end
        else if ( o_redirect.valid )
        begin
                // One bubble behind a redirect.
                o_decode   <= '0;
                o_redirect <= '0;
        end
        else
        begin
                o_decode   <= i_next;
                o_redirect <= i_redirect_next;
        end
end

endmodule

//--- src/predecode_top.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module predecode_top
(
        input  logic                                i_clk,
        input  logic                                i_reset,
        input  predecode_pipe_pkg::fetch_bundle_t   i_fetch,
        input  predecode_pipe_pkg::pipe_ctrl_t      i_ctrl,
        input  logic                                i_pred_valid,
        input  logic [`PREDECODE_XLEN-1:0]          i_pred_pc,
        input  logic                                i_cpu_mode_t,
        output predecode_pipe_pkg::decode_bundle_t  o_decode,
        output predecode_pipe_pkg::redirect_t       o_redirect,
        output logic                                o_clear_btb
);

predecode_isa_pkg::branch_class_t      br_class;
logic                                  br_link;
logic                                  br_always;
logic [`PREDECODE_XLEN-1:0]            br_target;
logic [`PREDECODE_XLEN-1:0]            br_fallthrough;
logic [`PREDECODE_XLEN-1:0]            ras_top;
logic                                  ras_push;
logic                                  ras_pop;
logic [`PREDECODE_XLEN-1:0]            ras_push_addr;
logic                                  advance;
predecode_pipe_pkg::decode_bundle_t    next_bundle;
predecode_pipe_pkg::redirect_t         next_redirect;

////////////////////////////////////////
// Classification.
////////////////////////////////////////

predecode_branch_decode u_branch_decode
(
        .i_instr       (i_fetch),
        .i_cpu_mode_t  (i_cpu_mode_t),
        .o_class       (br_class),
        .o_link        (br_link),
        .o_always      (br_always),
        .o_target      (br_target),
        .o_fallthrough (br_fallthrough)
);

predecode_ras u_ras
(
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_advance   (advance),
        .i_push      (ras_push),
        .i_pop       (ras_pop),
        .i_push_addr (ras_push_addr),
        .o_top_addr  (ras_top),
        .o_ptr       ()
);

////////////////////////////////////////
// Prediction and output register.
////////////////////////////////////////

predecode_predictor u_predictor
(
        .i_fetch         (i_fetch),
        .i_class         (br_class),
        .i_link          (br_link),
        .i_always        (br_always),
        .i_target        (br_target),
        .i_fallthrough   (br_fallthrough),
        .i_pred_valid    (i_pred_valid),
        .i_pred_pc       (i_pred_pc),
        .i_ras_top       (ras_top),
        .i_ppc_ff        (o_decode.ppc),
        .o_next          (next_bundle),
        .o_redirect_next (next_redirect),
        .o_push          (ras_push),
        .o_pop           (ras_pop),
        .o_push_addr     (ras_push_addr),
        .o_clear_btb     (o_clear_btb)
);

predecode_stage_reg u_stage_reg
(
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_ctrl          (i_ctrl),
        .i_next          (next_bundle),
        .i_redirect_next (next_redirect),
        .o_decode        (o_decode),
        .o_redirect      (o_redirect),
        .o_advance       (advance)
);

endmodule

//--- testbench/predecode_properties.sv
`timescale 1ns/1ps

module predecode_properties
(
        input logic                                i_clk,
        input logic                                i_reset,
        input predecode_pipe_pkg::pipe_ctrl_t      i_ctrl,
        input predecode_pipe_pkg::decode_bundle_t  i_decode,
        input predecode_pipe_pkg::redirect_t       i_redirect
);

logic held;

// Stall that no higher-priority clear overrides.
always_comb held = !i_ctrl.clear_wb &&
                   (i_ctrl.data_stall ||
                    (!i_ctrl.clear_alu && (i_ctrl.stall_shifter || i_ctrl.stall_issue)));

////////////////////////////////////////
// Redirect and bubble.
////////////////////////////////////////

redirect_then_bubble: assert property (@(posedge i_clk) disable iff (i_reset)
        i_redirect.valid && !held |=> !i_redirect.valid)
        else $error("Redirect stayed valid over two advancing cycles.");

////////////////////////////////////////
// Reset and hold.
////////////////////////////////////////

empty_after_reset: assert property (@(posedge i_clk)
        i_reset |=> !i_decode.valid && !i_redirect.valid)
        else $error("Output valid one cycle after reset.");

hold_keeps_decode: assert property (@(posedge i_clk) disable iff (i_reset)
        held |=> $stable(i_decode))
        else $error("Held stage changed its output bundle.");

endmodule

bind predecode_stage_reg predecode_properties u_properties
(
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ctrl     (i_ctrl),
        .i_decode   (o_decode),
        .i_redirect (o_redirect)
);

//--- testbench/predecode_tb.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module predecode_tb;

localparam int NUM_CYCLES     = 2000;
localparam int RESET_CYCLES   = 3;
// Stimulus length plus a quarter for slack.
localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;
localparam int DEPTH          = `PREDECODE_RAS_DEPTH;

logic                                i_clk;
logic                                i_reset;
predecode_pipe_pkg::fetch_bundle_t   i_fetch;
predecode_pipe_pkg::pipe_ctrl_t      i_ctrl;
logic                                i_pred_valid;
logic [`PREDECODE_XLEN-1:0]          i_pred_pc;
logic                                i_cpu_mode_t;
predecode_pipe_pkg::decode_bundle_t  o_decode;
predecode_pipe_pkg::redirect_t       o_redirect;
logic                                o_clear_btb;

// Model of the output register and the RAS.
predecode_pipe_pkg::decode_bundle_t  exp_decode;
predecode_pipe_pkg::redirect_t       exp_redirect;
logic                                exp_clear_btb;
logic [`PREDECODE_XLEN-1:0]          model_ras [DEPTH];
int                                  model_ptr;
logic                                held;
logic                                is_call;
logic                                is_ret;
string                               kind;
int                                  error_count;
int                                  check_count;
int                                  cycle_count;

predecode_top predecode_top_i
(
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_fetch      (i_fetch),
        .i_ctrl       (i_ctrl),
        .i_pred_valid (i_pred_valid),
        .i_pred_pc    (i_pred_pc),
        .i_cpu_mode_t (i_cpu_mode_t),
        .o_decode     (o_decode),
        .o_redirect   (o_redirect),
        .o_clear_btb  (o_clear_btb)
);

initial
begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
end

initial
begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
                @(posedge i_clk);
                cycle_count++;
        end
        $display("Timeout: run did not end within %0d cycles.", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
end

////////////////////////////////////////
// Reference rules.
////////////////////////////////////////

// PC+8 plus the offset, halfword scaled when bit 34 is set.
function automatic logic [`PREDECODE_XLEN-1:0] branch_target();
        logic [`PREDECODE_XLEN-1:0] off;

        off = `PREDECODE_XLEN'(signed'(i_fetch.instr[23:0]));
        if (i_fetch.instr[34])
                return i_fetch.pc_plus_8 + (off << 1);
        return i_fetch.pc_plus_8 + (off << 2);
endfunction

function automatic logic [`PREDECODE_XLEN-1:0] fallthrough();
        if (i_cpu_mode_t)
                return i_fetch.pc + `PREDECODE_THUMB_STEP;
        return i_fetch.pc + `PREDECODE_ARM_STEP;
endfunction

// Where a taken prediction would send fetch.
function automatic logic [`PREDECODE_XLEN-1:0] taken_pc();
        if (is_call)
                return branch_target();
        if (is_ret)
                return model_ras[(model_ptr + DEPTH - 1) % DEPTH];
        return fallthrough();
endfunction

task automatic report_mismatch
(
        input string        field,
        input logic [159:0] expected,
        input logic [159:0] actual
);
        error_count++;
        $display("ERROR %s %s: expected %0h, actual %0h", kind, field, expected, actual);
endtask

////////////////////////////////////////
// Stimulus.
////////////////////////////////////////

task automatic new_fetch();
        int         pick;
        logic [3:0] cond;
        logic [2:0] op;

        pick = $urandom_range(99);
        cond = ($urandom_range(3) == 0) ? 4'b1110 : 4'($urandom_range(13));
        i_fetch.taken     = predecode_isa_pkg::branch_state_t'($urandom_range(3));
        i_fetch.force32   = 1'($urandom_range(1));
        i_fetch.und       = ($urandom_range(15) == 0);
        i_fetch.irq       = ($urandom_range(15) == 0);
        i_fetch.fiq       = ($urandom_range(15) == 0);
        i_fetch.abt       = ($urandom_range(15) == 0);
        i_fetch.pc        = $urandom;
        i_fetch.pc_plus_8 = i_fetch.pc + 8;
        i_fetch.instr     = {3'($urandom_range(7)), $urandom};
        i_fetch.valid     = 1'b1;
        is_call = 1'b0;
        is_ret  = 1'b0;

        if (pick < 30)
        begin
                kind    = (pick < 15) ? "branch" : "call";
                is_call = 1'b1;
                i_fetch.instr[31:24] = {cond, 3'b101, pick >= 15};
        end
        else if (pick < 38)
        begin
                kind   = "bx_lr";
                is_ret = 1'b1;
                i_fetch.instr[31:0] = {cond, 28'h12f_ff1e};
        end
        else if (pick < 44)
        begin
                kind   = "mov_pc_lr";
                is_ret = 1'b1;
                i_fetch.instr = {3'b000, cond, 28'h1a0_f00e};
        end
        else if (pick < 50)
        begin
                kind   = "ldm_pc";
                is_ret = 1'b1;
                i_fetch.instr[31:25] = {cond, 3'b100};
                i_fetch.instr[20]    = 1'b1;
                i_fetch.instr[15]    = 1'b1;
        end
        else if (pick < 85)
        begin
                // Any opcode but branch and LDM; bit 0 set rules out LR forms.
                kind = "other";
                op   = 3'($urandom_range(5));
                if (op > 3'd3)
                        op = op + 3'd2;
                i_fetch.instr[27:25] = op;
                i_fetch.instr[0]     = 1'b1;
        end
        else
        begin
                kind          = "invalid";
                i_fetch.valid = 1'b0;
        end

        i_cpu_mode_t = 1'($urandom_range(1));
        i_pred_valid = ($urandom_range(2) == 0);
        i_pred_pc    = ($urandom_range(1) == 0) ? taken_pc() : $urandom;
endtask

task automatic new_ctrl();
        if ($urandom_range(99) < 20)
                i_ctrl = predecode_pipe_pkg::pipe_ctrl_t'(5'($urandom_range(31)));
        else
                i_ctrl = '0;
endtask

////////////////////////////////////////
// Model step and checks.
////////////////////////////////////////

task automatic model_step();
        predecode_pipe_pkg::decode_bundle_t nxt;
        predecode_pipe_pkg::redirect_t      nred;
        logic                               always_cond;
        logic                               predicted;
        logic                               push;
        logic                               pop;

        always_cond = (i_fetch.instr[31:28] == 4'b1110);
        predicted   = always_cond || (i_fetch.taken inside {predecode_isa_pkg::WT,
                                                            predecode_isa_pkg::ST});
        nxt = {i_fetch.instr, i_fetch.valid, i_fetch.taken, i_fetch.force32, i_fetch.irq,
               i_fetch.fiq, i_fetch.abt, i_fetch.und && i_fetch.valid, i_fetch.pc,
               i_fetch.pc_plus_8, exp_decode.ppc};
        nred          = '0;
        push          = 1'b0;
        pop           = 1'b0;
        exp_clear_btb = 1'b0;

        if ((is_call || is_ret) && predicted)
        begin
                nxt.ppc    = taken_pc();
                nred.pc    = nxt.ppc;
                nred.valid = !(i_pred_valid && i_pred_pc == nxt.ppc);
                if (always_cond)
                        nxt.taken = predecode_isa_pkg::ST;
                push = is_call && i_fetch.instr[24];
                pop  = is_ret;
        end
        else if (is_call || is_ret)
        begin
                nxt.ppc = fallthrough();
        end
        else
        begin
                nxt.taken = predecode_isa_pkg::SNT;
                if (i_fetch.valid && i_pred_valid)
                begin
                        nxt.ppc       = fallthrough();
                        nred.valid    = 1'b1;
                        nred.pc       = nxt.ppc;
                        exp_clear_btb = 1'b1;
                end
        end

        // Clear, stall, bubble, load.
        held = 1'b0;
        if (i_ctrl.clear_wb || (i_ctrl.clear_alu && !i_ctrl.data_stall))
        begin
                exp_decode.valid   = 1'b0;
                exp_decode.taken   = predecode_isa_pkg::SNT;
                exp_decode.irq     = 1'b0;
                exp_decode.fiq     = 1'b0;
                exp_decode.abt     = 1'b0;
                exp_decode.und     = 1'b0;
                exp_redirect.valid = 1'b0;
        end
        else if (i_ctrl.data_stall || i_ctrl.stall_shifter || i_ctrl.stall_issue)
        begin
                held = 1'b1;
        end
        else if (exp_redirect.valid)
        begin
                exp_decode   = '0;
                exp_redirect = '0;
        end
        else
        begin
                exp_decode   = nxt;
                exp_redirect = nred;
                if (push)
                begin
                        model_ras[model_ptr] = fallthrough();
                        model_ptr            = (model_ptr + 1) % DEPTH;
                end
                else if (pop)
                begin
                        model_ptr = (model_ptr + DEPTH - 1) % DEPTH;
                end
        end
endtask

task automatic check_outputs();
        check_count++;
        if (o_decode !== exp_decode)
                report_mismatch("o_decode", exp_decode, o_decode);
        if (o_redirect.valid !== exp_redirect.valid)
                report_mismatch("o_redirect.valid", exp_redirect.valid, o_redirect.valid);
        if (exp_redirect.valid && o_redirect.pc !== exp_redirect.pc)
                report_mismatch("o_redirect.pc", exp_redirect.pc, o_redirect.pc);
endtask

initial
begin
        void'($urandom(32'h2f84_3fa1));
        error_count  = 0;
        check_count  = 0;
        held         = 1'b0;
        kind         = "reset";
        exp_decode   = '0;
        exp_redirect = '0;
        model_ptr    = 0;
        for (int i = 0; i < DEPTH; i++)
                model_ras[i] = '0;
        i_reset      = 1'b1;
        i_fetch      = '0;
        i_ctrl       = '0;
        i_pred_valid = 1'b0;
        i_pred_pc    = '0;
        i_cpu_mode_t = 1'b0;

        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_outputs();

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
        begin
                // Fetch keeps its slot while the stage holds.
                if (!held)
                        new_fetch();
                new_ctrl();
                model_step();
                #1;
                check_count++;
                if (o_clear_btb !== exp_clear_btb)
                        report_mismatch("o_clear_btb", exp_clear_btb, o_clear_btb);
                @(posedge i_clk);
                #1;
                check_outputs();
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
                $display("Simulation passed");
        else
                $display("Simulation failed");
        $finish;
end

endmodule
